// File: src/frame_geom_pkg.sv
`default_nettype none

package frame_geom_pkg;

  localparam int PIXEL_W          = 16;   // rgb565
  localparam int PIXELS_PER_CHUNK = 8;    // pixel 0 in the low bits
  localparam int CHUNK_W          = PIXEL_W * PIXELS_PER_CHUNK;
  localparam int FRAME_CHUNKS     = 64;
  localparam int FRAME_PIXELS     = FRAME_CHUNKS * PIXELS_PER_CHUNK;
  localparam int FRAME_SLOTS      = 2;    // one slot written while the other is read
  localparam int READ_BUF_CHUNKS  = 2;    // reader chunk buffer entries

  // derived widths
  localparam int SLOT_W      = $clog2(FRAME_SLOTS);
  localparam int LANE_W      = $clog2(PIXELS_PER_CHUNK);
  localparam int CHUNK_IDX_W = $clog2(FRAME_CHUNKS);
  localparam int PIX_IDX_W   = $clog2(FRAME_PIXELS);
  localparam int BUF_PTR_W   = $clog2(READ_BUF_CHUNKS);
  localparam int BUF_CNT_W   = $clog2(READ_BUF_CHUNKS + 1);

  // test patterns, see pattern_stacker for the per-pixel rule
  typedef enum logic [1:0] {
    PAT_SOLID   = 2'd0,
    PAT_INDEX   = 2'd1,
    PAT_CHECKER = 2'd2,
    PAT_FRAME   = 2'd3
  } pattern_t;

endpackage

`default_nettype wire

// File: src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  // top address bit picks the frame slot, low six bits the chunk
  localparam int CHUNK_ADDR_W = 7;
  localparam int MEM_DEPTH    = 1 << CHUNK_ADDR_W;   // 128 chunks

  // what the arbiter asks the memory to do this cycle
  typedef enum logic [1:0] {
    MEM_IDLE  = 2'd0,
    MEM_WRITE = 2'd1,
    MEM_READ  = 2'd2
  } mem_op_t;

endpackage

`default_nettype wire

// File: src/chunk_memory.sv
`default_nettype none

module chunk_memory import frame_geom_pkg::*, mem_bus_pkg::*; (
  input  logic                    clk_camera,
  input  mem_op_t                 mem_op_i,
  input  logic [CHUNK_ADDR_W-1:0] mem_addr_i,
  input  logic [CHUNK_W-1:0]      mem_wdata_i,
  output logic [CHUNK_W-1:0]      mem_rdata_o    // valid the cycle after MEM_READ
);

  logic [CHUNK_W-1:0] mem [MEM_DEPTH];   // two slots of 64 chunks

  always_ff @(posedge clk_camera) begin
    case (mem_op_i)
      MEM_WRITE: mem[mem_addr_i] <= mem_wdata_i;
      MEM_READ:  mem_rdata_o     <= mem[mem_addr_i];
      default: ;                              // idle, hold output
    endcase
  end

endmodule

`default_nettype wire

// File: src/chunk_arbiter.sv
`default_nettype none

module chunk_arbiter import frame_geom_pkg::*, mem_bus_pkg::*; (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic                    wr_req_i,
  input  logic [CHUNK_ADDR_W-1:0] wr_addr_i,
  input  logic [CHUNK_W-1:0]      wr_data_i,
  input  logic                    rd_req_i,
  input  logic [CHUNK_ADDR_W-1:0] rd_addr_i,
  input  logic [CHUNK_W-1:0]      mem_rdata_i,
  output logic                    wr_grant_o,
  output logic                    rd_grant_o,
  output logic                    rd_valid_o,
  output logic [CHUNK_W-1:0]      rd_data_o,
  output mem_op_t                 mem_op_o,
  output logic [CHUNK_ADDR_W-1:0] mem_addr_o,
  output logic [CHUNK_W-1:0]      mem_wdata_o
);

  logic last_was_rd;   // peer served most recently, reader after reset

  // writer wins alone, or on a tie when the reader went last
  assign wr_grant_o = wr_req_i && (!rd_req_i || last_was_rd);
  assign rd_grant_o = rd_req_i && !wr_grant_o;

  always_comb begin
    if (wr_grant_o) mem_op_o = MEM_WRITE;
    else if (rd_grant_o) mem_op_o = MEM_READ;
    else mem_op_o = MEM_IDLE;
  end

  assign mem_addr_o  = wr_grant_o ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = wr_data_i;
  assign rd_data_o   = mem_rdata_i;   // memory output register already aligned to rd_valid

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      last_was_rd <= 1'b1;
      rd_valid_o  <= 1'b0;
    end else begin
      rd_valid_o <= rd_grant_o;          // one-cycle read latency
      if (wr_grant_o || rd_grant_o) last_was_rd <= rd_grant_o;
    end
  end

endmodule

`default_nettype wire

// File: src/pattern_stacker.sv
`default_nettype none

module pattern_stacker import frame_geom_pkg::*, mem_bus_pkg::*; (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic                    start_i,        // one-cycle strobe
  input  logic [SLOT_W-1:0]       slot_i,
  input  pattern_t                pattern_sel_i,
  input  logic                    wr_grant_i,     // one-cycle pulse, memory writes on this edge
  output logic                    wr_req_o,
  output logic [CHUNK_ADDR_W-1:0] wr_addr_o,
  output logic [CHUNK_W-1:0]      wr_data_o,
  output logic                    done_o,
  output logic                    busy_o,
  output logic [7:0]              frame_count_o
);

  logic                 packing;      // pixel counter still running
  logic [PIX_IDX_W-1:0] pix_cnt;      // index of the pixel being evaluated
  logic [CHUNK_W-1:0]   pack_q;       // partial chunk, new pixels enter at the top
  logic [SLOT_W-1:0]    slot_q;
  pattern_t             pat_q;
  logic [PIXEL_W-1:0]   pix_val;
  logic                 chunk_end;    // current pixel completes a chunk
  logic                 pix_step;

  assign chunk_end = (pix_cnt[LANE_W-1:0] == LANE_W'(PIXELS_PER_CHUNK - 1));
  // only stall when the hold register is still waiting and the 8th pixel is due
  assign pix_step  = packing && !(chunk_end && wr_req_o && !wr_grant_i);

  // pattern rule for pixel pix_cnt
  always_comb begin
    case (pat_q)
      PAT_SOLID:   pix_val = 16'hF800;                      // red
      PAT_INDEX:   pix_val = PIXEL_W'(pix_cnt);
      PAT_CHECKER: pix_val = (pix_cnt[3] ^ pix_cnt[6]) ? '1 : '0;
      PAT_FRAME:   pix_val = {~frame_count_o, frame_count_o};
      default:     pix_val = '0;
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      busy_o        <= 1'b0;
      packing       <= 1'b0;
      pix_cnt       <= '0;
      wr_req_o      <= 1'b0;
      done_o        <= 1'b0;
      frame_count_o <= '0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy_o) begin     // strobes while busy are dropped
        busy_o  <= 1'b1;
        packing <= 1'b1;
        pix_cnt <= '0;
      end
      if (pix_step) begin
        pix_cnt <= pix_cnt + 1'b1;
        if (pix_cnt == PIX_IDX_W'(FRAME_PIXELS - 1)) packing <= 1'b0;
      end
      if (wr_grant_i) begin
        wr_req_o <= 1'b0;
        if (wr_addr_o[CHUNK_IDX_W-1:0] == CHUNK_IDX_W'(FRAME_CHUNKS - 1)) begin
          done_o        <= 1'b1;        // last chunk accepted
          busy_o        <= 1'b0;
          frame_count_o <= frame_count_o + 1'b1;
        end
      end
      if (pix_step && chunk_end) wr_req_o <= 1'b1;  // new chunk lands in hold
    end
  end

  // payload, loaded on capture and on each pixel step
  always_ff @(posedge clk_camera) begin
    if (start_i && !busy_o) begin
      slot_q <= slot_i;
      pat_q  <= pattern_sel_i;
    end
    if (pix_step) begin
      pack_q <= {pix_val, pack_q[CHUNK_W-1:PIXEL_W]};
      if (chunk_end) begin
        wr_data_o <= {pix_val, pack_q[CHUNK_W-1:PIXEL_W]};
        wr_addr_o <= {slot_q, pix_cnt[PIX_IDX_W-1:LANE_W]};
      end
    end
  end

endmodule

`default_nettype wire

// File: src/frame_reader.sv
`default_nettype none

module frame_reader import frame_geom_pkg::*, mem_bus_pkg::*; (
  input  logic                    clk_camera,
  input  logic                    recent_reset,
  input  logic                    start_i,       // one-cycle strobe
  input  logic [SLOT_W-1:0]       slot_i,
  input  logic                    rd_grant_i,    // one-cycle pulse
  input  logic                    rd_valid_i,    // one cycle after the grant
  input  logic [CHUNK_W-1:0]      rd_data_i,
  input  logic                    pixel_ready_i,
  output logic                    rd_req_o,
  output logic [CHUNK_ADDR_W-1:0] rd_addr_o,
  output logic                    pixel_valid_o,
  output logic [PIXEL_W-1:0]      pixel_data_o,
  output logic                    pixel_last_o,
  output logic                    busy_o
);

  logic                   req_active;    // chunks left to request
  logic [CHUNK_IDX_W-1:0] req_idx;
  logic [BUF_CNT_W-1:0]   credits;       // free entries not yet claimed by a read
  logic [BUF_CNT_W-1:0]   buf_cnt;       // filled entries
  logic [BUF_PTR_W-1:0]   wr_ptr;
  logic [BUF_PTR_W-1:0]   rd_ptr;
  logic [PIX_IDX_W-1:0]   out_idx;       // next pixel to hand out
  logic [SLOT_W-1:0]      slot_q;
  logic [CHUNK_W-1:0]     chunk_buf [READ_BUF_CHUNKS];
  logic                   take;
  logic                   pop;

  assign rd_req_o  = req_active && (credits != '0);
  assign rd_addr_o = {slot_q, req_idx};

  // unpack side, pixel held steady until taken
  assign pixel_valid_o = (buf_cnt != '0);
  assign pixel_data_o  = chunk_buf[rd_ptr][out_idx[LANE_W-1:0]*PIXEL_W +: PIXEL_W];
  assign pixel_last_o  = pixel_valid_o && (out_idx == PIX_IDX_W'(FRAME_PIXELS - 1));
  assign take = pixel_valid_o && pixel_ready_i;
  assign pop  = take && (out_idx[LANE_W-1:0] == LANE_W'(PIXELS_PER_CHUNK - 1));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      busy_o     <= 1'b0;
      req_active <= 1'b0;
      req_idx    <= '0;
      credits    <= BUF_CNT_W'(READ_BUF_CHUNKS);
      buf_cnt    <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      out_idx    <= '0;
    end else begin
      if (start_i && !busy_o) begin
        busy_o     <= 1'b1;
        req_active <= 1'b1;
        req_idx    <= '0;
        out_idx    <= '0;
      end
      if (rd_grant_i) begin
        req_idx <= req_idx + 1'b1;
        if (req_idx == CHUNK_IDX_W'(FRAME_CHUNKS - 1)) req_active <= 1'b0;
      end
      // a credit goes with each grant and comes back when its chunk is drained
      credits <= credits - BUF_CNT_W'(rd_grant_i) + BUF_CNT_W'(pop);
      buf_cnt <= buf_cnt + BUF_CNT_W'(rd_valid_i) - BUF_CNT_W'(pop);
      if (rd_valid_i) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (take) begin
        out_idx <= out_idx + 1'b1;
        if (pixel_last_o) busy_o <= 1'b0;   // frame fully drained
      end
    end
  end

  // chunk storage
  always_ff @(posedge clk_camera) begin
    if (rd_valid_i) chunk_buf[wr_ptr] <= rd_data_i;
    if (start_i && !busy_o) slot_q <= slot_i;
  end

endmodule

`default_nettype wire

// File: src/frame_store_top.sv
`default_nettype none

module frame_store_top import frame_geom_pkg::*, mem_bus_pkg::*; (
  input  logic               clk_camera,
  input  logic               recent_reset,
  input  logic               write_start_i,
  input  logic [SLOT_W-1:0]  write_slot_i,
  input  pattern_t           pattern_sel_i,
  input  logic               read_start_i,
  input  logic [SLOT_W-1:0]  read_slot_i,
  input  logic               pixel_ready_i,
  output logic               write_done_o,
  output logic               write_busy_o,
  output logic               read_busy_o,
  output logic               pixel_valid_o,
  output logic [PIXEL_W-1:0] pixel_data_o,
  output logic               pixel_last_o
);

  // writer side
  logic                    wr_req;
  logic                    wr_grant;
  logic [CHUNK_ADDR_W-1:0] wr_addr;
  logic [CHUNK_W-1:0]      wr_data;

  // reader side
  logic                    rd_req;
  logic                    rd_grant;
  logic                    rd_valid;
  logic [CHUNK_ADDR_W-1:0] rd_addr;
  logic [CHUNK_W-1:0]      rd_data;

  // memory port
  mem_op_t                 mem_op;
  logic [CHUNK_ADDR_W-1:0] mem_addr;
  logic [CHUNK_W-1:0]      mem_wdata;
  logic [CHUNK_W-1:0]      mem_rdata;

  pattern_stacker u_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .start_i       (write_start_i),
    .slot_i        (write_slot_i),
    .pattern_sel_i (pattern_sel_i),
    .wr_grant_i    (wr_grant),
    .wr_req_o      (wr_req),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .done_o        (write_done_o),
    .busy_o        (write_busy_o),
    .frame_count_o ()                 // only used inside for PAT_FRAME
  );

  frame_reader u_reader (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .start_i       (read_start_i),
    .slot_i        (read_slot_i),
    .rd_grant_i    (rd_grant),
    .rd_valid_i    (rd_valid),
    .rd_data_i     (rd_data),
    .pixel_ready_i (pixel_ready_i),
    .rd_req_o      (rd_req),
    .rd_addr_o     (rd_addr),
    .pixel_valid_o (pixel_valid_o),
    .pixel_data_o  (pixel_data_o),
    .pixel_last_o  (pixel_last_o),
    .busy_o        (read_busy_o)
  );

  chunk_arbiter u_arbiter (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .wr_req_i     (wr_req),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .mem_rdata_i  (mem_rdata),
    .wr_grant_o   (wr_grant),
    .rd_grant_o   (rd_grant),
    .rd_valid_o   (rd_valid),
    .rd_data_o    (rd_data),
    .mem_op_o     (mem_op),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata)
  );

  chunk_memory u_memory (
    .clk_camera  (clk_camera),
    .mem_op_i    (mem_op),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: sim/frame_store_tb.sv
`default_nettype none

module frame_store_tb import frame_geom_pkg::*, mem_bus_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic               clk_camera;
  logic               recent_reset;
  logic               write_start_i;
  logic [SLOT_W-1:0]  write_slot_i;
  pattern_t           pattern_sel_i;
  logic               read_start_i;
  logic [SLOT_W-1:0]  read_slot_i;
  logic               pixel_ready_i = 1'b0;
  logic               write_done_o;
  logic               write_busy_o;
  logic               read_busy_o;
  logic               pixel_valid_o;
  logic [PIXEL_W-1:0] pixel_data_o;
  logic               pixel_last_o;

  // stimulus records, one entry per line of the stim file
  logic [7:0]  rec_cmd [$];
  int          rec_wslot [$];
  int          rec_pat [$];
  int          rec_rslot [$];
  int          rec_mode [$];

  logic [15:0] exp_pix [];            // expected pixels, slot-major
  string       test_name = "reset";
  int          done_count = 0;        // write_done_o pulses seen
  int          writes_issued = 0;     // accepted write strobes
  int          pix_idx = 0;           // next pixel expected from the reader
  int          read_slot = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic        reading = 1'b0;
  logic        throttle = 1'b0;       // ready from the xorshift stream
  logic [31:0] rng_state = 32'h830404dd;

  frame_store_top UUT (.*);

  always #20 clk_camera = ~clk_camera;   // 40 ns period

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected pixel p of a frame, patterns numbered as in the stim file
  function automatic logic [15:0] pattern_pixel(input int pat, input int p, input int frames);
    logic [7:0] fc;
    fc = 8'(frames);                   // write counter wraps at 256
    case (pat)
      0:       return 16'hF800;        // solid red
      1:       return 16'(p);
      2:       return (p[3] != p[6]) ? 16'hFFFF : 16'h0000;
      default: return {~fc, fc};
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic fill_model(input int slot, input int pat);
    for (int p = 0; p < FRAME_PIXELS; p++) begin
      exp_pix[slot * FRAME_PIXELS + p] = pattern_pixel(pat, p, done_count);
    end
  endtask

  // one strobe cycle for the writer, the reader or both together
  task automatic launch(input logic do_write, input logic do_read, input int wslot,
                        input int pat, input int rslot, input int mode);
    @(posedge clk_camera);
    #2;
    if (do_write) begin
      fill_model(wslot, pat);          // frame count is fixed for the whole write
      write_slot_i  = SLOT_W'(wslot);
      pattern_sel_i = pattern_t'(pat);
      write_start_i = 1'b1;
    end
    if (do_read) begin
      read_slot    = rslot;
      reading      = 1'b1;
      throttle    <= (mode != 0);      // ready driver sees it from the next cycle
      read_slot_i  = SLOT_W'(rslot);
      read_start_i = 1'b1;
    end
    @(posedge clk_camera);
    #2;
    write_start_i = 1'b0;
    read_start_i  = 1'b0;
  endtask

  // a second write strobe with other slot and pattern, must be dropped
  task automatic ignored_strobe(input int slot, input int pat);
    repeat (5) begin
      @(posedge clk_camera);
      #2;
    end
    check_value("write_busy_o during write", 1, 32'(write_busy_o));
    write_slot_i  = SLOT_W'(slot ^ 1);
    pattern_sel_i = pattern_t'(2'(pat + 1));
    write_start_i = 1'b1;
    @(posedge clk_camera);
    #2;
    write_start_i = 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk_camera);
      #2;
    end while (write_busy_o || read_busy_o);
    @(posedge clk_camera);              // let the monitor count the last done pulse
    #2;
    reading = 1'b0;
  endtask

  always @(posedge clk_camera) begin
    #2;
    rng_state     = xorshift32(rng_state);
    pixel_ready_i = throttle ? rng_state[0] : 1'b1;
  end

  // output monitor, samples mid-cycle
  always @(negedge clk_camera) begin
    if (!recent_reset) begin
      if (write_done_o) done_count++;
      if (read_start_i) pix_idx = 0;
      if (pixel_valid_o) begin
        check_value("pixel_valid_o with no read", 1, 32'(reading));
        check_value("pixel beyond frame", 1, 32'(pix_idx < FRAME_PIXELS));
        check_value($sformatf("pixel %0d", pix_idx),
                    32'(exp_pix[read_slot * FRAME_PIXELS + pix_idx]), 32'(pixel_data_o));
        check_value("pixel_last_o", 32'(pix_idx == FRAME_PIXELS - 1), 32'(pixel_last_o));
        if (pixel_ready_i) pix_idx++;   // taken at the next edge
      end
    end
  end

  always @(posedge clk_camera) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT did not finish the records", cycles);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] cmd;
    int         ws;
    int         pat;
    int         rs;
    int         mode;
    clk_camera    = 1'b0;
    recent_reset  = 1'b1;
    write_start_i = 1'b0;
    write_slot_i  = '0;
    pattern_sel_i = PAT_SOLID;
    read_start_i  = 1'b0;
    read_slot_i   = '0;
    exp_pix = new[FRAME_SLOTS * FRAME_PIXELS];
    fd = $fopen("sim/frame_store_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/frame_store_stim.txt");
      $display("Simulation failed");
      $fatal(1);
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments and blanks
        n = $sscanf(line, "%c %d %d %d %d", cmd, ws, pat, rs, mode);
        if (n != 5) begin
          $display("stimulus line has %0d fields instead of 5: %s", n, line);
          $display("Simulation failed");
          $fatal(1);
        end
        rec_cmd.push_back(cmd);
        rec_wslot.push_back(ws);
        rec_pat.push_back(pat);
        rec_rslot.push_back(rs);
        rec_mode.push_back(mode);
      end
    end
    $fclose(fd);
    cycle_limit = rec_cmd.size() * 4 * FRAME_PIXELS + 200;

    repeat (10) @(posedge clk_camera);
    #2;
    recent_reset = 1'b0;
    @(posedge clk_camera);
    #2;
    check_value("write_busy_o after reset", 0, 32'(write_busy_o));
    check_value("read_busy_o after reset", 0, 32'(read_busy_o));
    check_value("write_done_o after reset", 0, 32'(write_done_o));
    check_value("pixel_valid_o after reset", 0, 32'(pixel_valid_o));

    foreach (rec_cmd[i]) begin
      test_name = $sformatf("record %0d (%c)", i + 1, rec_cmd[i]);
      case (rec_cmd[i])
        "W": begin
          launch(1'b1, 1'b0, rec_wslot[i], rec_pat[i], 0, 0);
          ignored_strobe(rec_wslot[i], rec_pat[i]);
        end
        "R": launch(1'b0, 1'b1, 0, 0, rec_rslot[i], rec_mode[i]);
        "C": begin                       // write one slot while the other is read
          launch(1'b1, 1'b1, rec_wslot[i], rec_pat[i], rec_rslot[i], rec_mode[i]);
          ignored_strobe(rec_wslot[i], rec_pat[i]);
        end
        default: begin
          $display("unknown command letter in stimulus record %0d", i + 1);
          $display("Simulation failed");
          $fatal(1);
        end
      endcase
      wait_idle();
      if (rec_cmd[i] != "R") writes_issued++;
      check_value("write_done_o pulses", 32'(writes_issued), 32'(done_count));
      if (rec_cmd[i] != "W") check_value("pixels read", FRAME_PIXELS, 32'(pix_idx));
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/frame_store_stim.txt
# cmd wslot pattern(0 solid 1 index 2 checker 3 frame) rslot ready(0 high 1 xorshift)
W 0 0 0 0
R 0 0 0 0
W 1 1 1 0
R 0 0 1 0
W 0 2 0 0
R 0 0 0 1
W 0 3 0 0
W 0 3 0 0
R 0 0 0 0
C 1 2 0 1
R 0 0 1 1

// File: frame_store.f
src/frame_geom_pkg.sv
src/mem_bus_pkg.sv
src/chunk_memory.sv
src/chunk_arbiter.sv
src/pattern_stacker.sv
src/frame_reader.sv
src/frame_store_top.sv
sim/frame_store_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= frame_store_tb
FILELIST  ?= frame_store.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

# build, run, then decide pass or fail from the printed output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
